/* source/axi_ram_pkg.sv */
// Widths, memory depth and AXI channel structs shared by every block of the RAM subsystem
package axi_ram_pkg;

	////////////////////
	// Bus geometry
	localparam int ID_WIDTH = 4;
	localparam int DATA_WIDTH = 32;
	localparam int STRB_WIDTH = DATA_WIDTH / 8;

	////////////////////
	// Memory geometry
	localparam int MEMORY_DEPTH = 1024;
	// Byte offset bits inside one word
	localparam int ADDR_LSB = $clog2(STRB_WIDTH);
	localparam int ADDR_WIDTH = $clog2(MEMORY_DEPTH) + ADDR_LSB;

	////////////////////
	// Arbitration
	localparam int NUM_MASTERS = 2;
	localparam int MASTER_SEL_WIDTH = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

	// Only response code ever returned
	localparam logic [1:0] RESP_OKAY = 2'b00;

	// Write address beat, INCR at full width implied
	typedef struct packed {
		logic [ID_WIDTH-1:0] id;
		logic [ADDR_WIDTH-1:0] addr;
		logic [7:0] len;
	} axi_aw_t;

	// Write data beat
	typedef struct packed {
		logic [DATA_WIDTH-1:0] data;
		logic [STRB_WIDTH-1:0] strb;
		logic last;
	} axi_w_t;

	// Write response
	typedef struct packed {
		logic [ID_WIDTH-1:0] id;
		logic [1:0] resp;
	} axi_b_t;

	// Read address beat
	typedef struct packed {
		logic [ID_WIDTH-1:0] id;
		logic [ADDR_WIDTH-1:0] addr;
		logic [7:0] len;
	} axi_ar_t;

	// Read data beat
	typedef struct packed {
		logic [ID_WIDTH-1:0] id;
		logic [DATA_WIDTH-1:0] data;
		logic [1:0] resp;
		logic last;
	} axi_r_t;

endpackage

/* source/axi_skid_buffer.sv */
// Two-entry register slice for one valid/ready channel, instantiated once per AXI channel type
`timescale 1ns/100ps

module axi_skid_buffer #(
	parameter type payload_t = logic
) (
	input logic aclk,
	input logic aresetn,
	input payload_t in_data,
	input logic in_valid,
	output logic in_ready,
	output payload_t out_data,
	output logic out_valid,
	input logic out_ready
);

	payload_t skid_data;
	logic skid_valid;
	logic main_load;

	// Output register is empty or being drained this cycle
	assign main_load = !out_valid || out_ready;

	// Stop accepting only once the skid entry is occupied too
	assign in_ready = !skid_valid;

	////////////////////
	// Fill state
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			out_valid <= 1'b0;
			skid_valid <= 1'b0;
		end else if (main_load) begin
			// Skid entry drains first so order holds
			out_valid <= skid_valid || in_valid;
			skid_valid <= 1'b0;
		end else if (in_valid && in_ready) begin
			skid_valid <= 1'b1;
		end
	end

	////////////////////
	// Payload
	always_ff @(posedge aclk) begin
		if (main_load) begin
			out_data <= skid_valid ? skid_data : in_data;
		end
		// Output stalled, park the incoming item
		if (!main_load && in_valid && in_ready) begin
			skid_data <= in_data;
		end
	end

endmodule

/* source/axi_ram.sv */
// AXI4 burst RAM with byte strobes, one write and one read burst in flight, behind the arbiter
`timescale 1ns/100ps

module axi_ram (
	input logic aclk,
	input logic aresetn,
	// Write address
	input axi_ram_pkg::axi_aw_t aw,
	input logic aw_valid,
	output logic aw_ready,
	// Write data
	input axi_ram_pkg::axi_w_t w,
	input logic w_valid,
	output logic w_ready,
	// Write response
	output axi_ram_pkg::axi_b_t b,
	output logic b_valid,
	input logic b_ready,
	// Read address
	input axi_ram_pkg::axi_ar_t ar,
	input logic ar_valid,
	output logic ar_ready,
	// Read data
	output axi_ram_pkg::axi_r_t r,
	output logic r_valid,
	input logic r_ready
);

	logic [axi_ram_pkg::ADDR_WIDTH-1:0] write_addr;
	logic [axi_ram_pkg::ADDR_WIDTH-1:0] read_addr;
	logic [axi_ram_pkg::ID_WIDTH-1:0] write_id;
	logic [axi_ram_pkg::ID_WIDTH-1:0] read_id;
	logic [7:0] read_len;
	logic read_start;
	logic read_last;
	logic [axi_ram_pkg::STRB_WIDTH-1:0][7:0] read_data;
	logic aw_fire;
	logic w_fire;
	logic b_fire;
	logic ar_fire;
	logic r_fire;
	logic read_strobe;

	assign aw_fire = aw_valid && aw_ready;
	assign w_fire = w_valid && w_ready;
	assign b_fire = b_valid && b_ready;
	assign ar_fire = ar_valid && ar_ready;
	assign r_fire = r_valid && r_ready;

	// Fetch the first word after the address, then one per accepted beat
	assign read_strobe = read_start || r_fire;

	assign b = '{id: write_id, resp: axi_ram_pkg::RESP_OKAY};
	assign r = '{id: read_id, data: read_data, resp: axi_ram_pkg::RESP_OKAY, last: read_last};

	////////////////////
	// Write path
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			aw_ready <= 1'b1;
			w_ready <= 1'b0;
			b_valid <= 1'b0;
		end else begin
			if (aw_fire) begin
				aw_ready <= 1'b0;
			end else if (b_fire) begin
				aw_ready <= 1'b1;
			end
			if (aw_fire) begin
				w_ready <= 1'b1;
			end else if (w_fire && w.last) begin
				w_ready <= 1'b0;
			end
			if (w_fire && w.last) begin
				b_valid <= 1'b1;
			end else if (b_fire) begin
				b_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (aw_fire) begin
			write_id <= aw.id;
			write_addr <= aw.addr;
		end else if (w_fire) begin
			write_addr <= write_addr + axi_ram_pkg::ADDR_WIDTH'(axi_ram_pkg::STRB_WIDTH);
		end
	end

	////////////////////
	// Read path
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			ar_ready <= 1'b1;
			read_start <= 1'b0;
			r_valid <= 1'b0;
		end else begin
			read_start <= ar_fire;
			if (ar_fire) begin
				ar_ready <= 1'b0;
			end else if (r_fire && read_last) begin
				ar_ready <= 1'b1;
			end
			if (read_start) begin
				r_valid <= 1'b1;
			end else if (r_fire && read_last) begin
				r_valid <= 1'b0;
			end
		end
	end

	// Length counts down once per fetched word
	always_ff @(posedge aclk) begin
		if (ar_fire) begin
			read_id <= ar.id;
			read_addr <= ar.addr;
			read_len <= ar.len;
		end else if (read_strobe) begin
			read_addr <= read_addr + axi_ram_pkg::ADDR_WIDTH'(axi_ram_pkg::STRB_WIDTH);
			read_len <= read_len - 8'd1;
		end
		if (read_strobe) begin
			read_last <= (read_len == 8'd0);
		end
	end

	////////////////////
	// Byte banks
	for (genvar i = 0; i < axi_ram_pkg::STRB_WIDTH; i++) begin : g_bank
		logic [7:0] mem [axi_ram_pkg::MEMORY_DEPTH];
		logic [7:0] rd_byte;

		always_ff @(posedge aclk) begin
			if (w_fire && w.strb[i]) begin
				mem[write_addr[axi_ram_pkg::ADDR_WIDTH-1:axi_ram_pkg::ADDR_LSB]] <= w.data[i*8 +: 8];
			end
			if (read_strobe) begin
				rd_byte <= mem[read_addr[axi_ram_pkg::ADDR_WIDTH-1:axi_ram_pkg::ADDR_LSB]];
			end
		end

		assign read_data[i] = rd_byte;
	end

endmodule

/* source/axi_burst_arbiter.sv */
// Round-robin burst arbiter steering two AXI4 masters onto one slave, write and read granted apart
`timescale 1ns/100ps

module axi_burst_arbiter (
	input logic aclk,
	input logic aresetn,
	// Master side
	input axi_ram_pkg::axi_aw_t [axi_ram_pkg::NUM_MASTERS-1:0] m_aw,
	input logic [axi_ram_pkg::NUM_MASTERS-1:0] m_aw_valid,
	output logic [axi_ram_pkg::NUM_MASTERS-1:0] m_aw_ready,
	input axi_ram_pkg::axi_w_t [axi_ram_pkg::NUM_MASTERS-1:0] m_w,
	input logic [axi_ram_pkg::NUM_MASTERS-1:0] m_w_valid,
	output logic [axi_ram_pkg::NUM_MASTERS-1:0] m_w_ready,
	output axi_ram_pkg::axi_b_t [axi_ram_pkg::NUM_MASTERS-1:0] m_b,
	output logic [axi_ram_pkg::NUM_MASTERS-1:0] m_b_valid,
	input logic [axi_ram_pkg::NUM_MASTERS-1:0] m_b_ready,
	input axi_ram_pkg::axi_ar_t [axi_ram_pkg::NUM_MASTERS-1:0] m_ar,
	input logic [axi_ram_pkg::NUM_MASTERS-1:0] m_ar_valid,
	output logic [axi_ram_pkg::NUM_MASTERS-1:0] m_ar_ready,
	output axi_ram_pkg::axi_r_t [axi_ram_pkg::NUM_MASTERS-1:0] m_r,
	output logic [axi_ram_pkg::NUM_MASTERS-1:0] m_r_valid,
	input logic [axi_ram_pkg::NUM_MASTERS-1:0] m_r_ready,
	// Slave side
	output axi_ram_pkg::axi_aw_t s_aw,
	output logic s_aw_valid,
	input logic s_aw_ready,
	output axi_ram_pkg::axi_w_t s_w,
	output logic s_w_valid,
	input logic s_w_ready,
	input axi_ram_pkg::axi_b_t s_b,
	input logic s_b_valid,
	output logic s_b_ready,
	output axi_ram_pkg::axi_ar_t s_ar,
	output logic s_ar_valid,
	input logic s_ar_ready,
	input axi_ram_pkg::axi_r_t s_r,
	input logic s_r_valid,
	output logic s_r_ready
);

	logic [axi_ram_pkg::MASTER_SEL_WIDTH-1:0] wr_grant;
	logic [axi_ram_pkg::MASTER_SEL_WIDTH-1:0] wr_last;
	logic [axi_ram_pkg::MASTER_SEL_WIDTH-1:0] wr_pick;
	logic [axi_ram_pkg::MASTER_SEL_WIDTH-1:0] rd_grant;
	logic [axi_ram_pkg::MASTER_SEL_WIDTH-1:0] rd_last;
	logic [axi_ram_pkg::MASTER_SEL_WIDTH-1:0] rd_pick;
	logic wr_busy;
	logic rd_busy;

	// First requester after the previous winner; the previous winner comes last
	function automatic logic [axi_ram_pkg::MASTER_SEL_WIDTH-1:0] rr_pick(
		input logic [axi_ram_pkg::NUM_MASTERS-1:0] req,
		input logic [axi_ram_pkg::MASTER_SEL_WIDTH-1:0] last
	);
		int cand;
		logic [axi_ram_pkg::MASTER_SEL_WIDTH-1:0] pick;
		pick = last;
		for (int k = axi_ram_pkg::NUM_MASTERS; k >= 1; k--) begin
			cand = (int'(last) + k) % axi_ram_pkg::NUM_MASTERS;
			if (req[cand]) begin
				pick = cand[axi_ram_pkg::MASTER_SEL_WIDTH-1:0];
			end
		end
		return pick;
	endfunction

	////////////////////
	// Write path
	assign wr_pick = rr_pick(m_aw_valid, wr_last);
	// Address passes only while idle, the grant locks on its handshake
	assign s_aw = m_aw[wr_pick];
	assign s_aw_valid = !wr_busy && (|m_aw_valid);
	assign s_w = m_w[wr_grant];
	assign s_w_valid = wr_busy && m_w_valid[wr_grant];
	assign s_b_ready = wr_busy && m_b_ready[wr_grant];

	always_comb begin
		for (int i = 0; i < axi_ram_pkg::NUM_MASTERS; i++) begin
			m_aw_ready[i] = !wr_busy && s_aw_ready && (!(|m_aw_valid) || wr_pick == i);
			m_w_ready[i] = wr_busy && (wr_grant == i) && s_w_ready;
			m_b[i] = s_b;
			m_b_valid[i] = wr_busy && (wr_grant == i) && s_b_valid;
		end
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			wr_busy <= 1'b0;
			wr_grant <= '0;
			// Port 0 wins the first tie
			wr_last <= '1;
		end else if (!wr_busy) begin
			if (s_aw_valid && s_aw_ready) begin
				wr_busy <= 1'b1;
				wr_grant <= wr_pick;
				wr_last <= wr_pick;
			end
		end else if (s_b_valid && s_b_ready) begin
			wr_busy <= 1'b0;
		end
	end

	////////////////////
	// Read path
	assign rd_pick = rr_pick(m_ar_valid, rd_last);
	assign s_ar = m_ar[rd_pick];
	assign s_ar_valid = !rd_busy && (|m_ar_valid);
	assign s_r_ready = rd_busy && m_r_ready[rd_grant];

	always_comb begin
		for (int i = 0; i < axi_ram_pkg::NUM_MASTERS; i++) begin
			m_ar_ready[i] = !rd_busy && s_ar_ready && (!(|m_ar_valid) || rd_pick == i);
			m_r[i] = s_r;
			m_r_valid[i] = rd_busy && (rd_grant == i) && s_r_valid;
		end
	end

	// Held until the beat carrying last is taken
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			rd_busy <= 1'b0;
			rd_grant <= '0;
			rd_last <= '1;
		end else if (!rd_busy) begin
			if (s_ar_valid && s_ar_ready) begin
				rd_busy <= 1'b1;
				rd_grant <= rd_pick;
				rd_last <= rd_pick;
			end
		end else if (s_r_valid && s_r_ready && s_r.last) begin
			rd_busy <= 1'b0;
		end
	end

endmodule

/* source/axi_ram_subsystem.sv */
// Top level of the shared AXI4 RAM, two master ports through the arbiter and slices to the RAM
`timescale 1ns/100ps

module axi_ram_subsystem (
	input logic aclk,
	input logic aresetn,
	input axi_ram_pkg::axi_aw_t [axi_ram_pkg::NUM_MASTERS-1:0] m_aw,
	input logic [axi_ram_pkg::NUM_MASTERS-1:0] m_aw_valid,
	output logic [axi_ram_pkg::NUM_MASTERS-1:0] m_aw_ready,
	input axi_ram_pkg::axi_w_t [axi_ram_pkg::NUM_MASTERS-1:0] m_w,
	input logic [axi_ram_pkg::NUM_MASTERS-1:0] m_w_valid,
	output logic [axi_ram_pkg::NUM_MASTERS-1:0] m_w_ready,
	output axi_ram_pkg::axi_b_t [axi_ram_pkg::NUM_MASTERS-1:0] m_b,
	output logic [axi_ram_pkg::NUM_MASTERS-1:0] m_b_valid,
	input logic [axi_ram_pkg::NUM_MASTERS-1:0] m_b_ready,
	input axi_ram_pkg::axi_ar_t [axi_ram_pkg::NUM_MASTERS-1:0] m_ar,
	input logic [axi_ram_pkg::NUM_MASTERS-1:0] m_ar_valid,
	output logic [axi_ram_pkg::NUM_MASTERS-1:0] m_ar_ready,
	output axi_ram_pkg::axi_r_t [axi_ram_pkg::NUM_MASTERS-1:0] m_r,
	output logic [axi_ram_pkg::NUM_MASTERS-1:0] m_r_valid,
	input logic [axi_ram_pkg::NUM_MASTERS-1:0] m_r_ready
);

	////////////////////
	// Arbiter to slices
	axi_ram_pkg::axi_aw_t arb_aw;
	logic arb_aw_valid, arb_aw_ready;
	axi_ram_pkg::axi_w_t arb_w;
	logic arb_w_valid, arb_w_ready;
	axi_ram_pkg::axi_b_t arb_b;
	logic arb_b_valid, arb_b_ready;
	axi_ram_pkg::axi_ar_t arb_ar;
	logic arb_ar_valid, arb_ar_ready;
	axi_ram_pkg::axi_r_t arb_r;
	logic arb_r_valid, arb_r_ready;

	////////////////////
	// Slices to RAM
	axi_ram_pkg::axi_aw_t ram_aw;
	logic ram_aw_valid, ram_aw_ready;
	axi_ram_pkg::axi_w_t ram_w;
	logic ram_w_valid, ram_w_ready;
	axi_ram_pkg::axi_b_t ram_b;
	logic ram_b_valid, ram_b_ready;
	axi_ram_pkg::axi_ar_t ram_ar;
	logic ram_ar_valid, ram_ar_ready;
	axi_ram_pkg::axi_r_t ram_r;
	logic ram_r_valid, ram_r_ready;

	axi_burst_arbiter arbiter_i (
		.aclk(aclk), .aresetn(aresetn),
		.m_aw(m_aw), .m_aw_valid(m_aw_valid), .m_aw_ready(m_aw_ready),
		.m_w(m_w), .m_w_valid(m_w_valid), .m_w_ready(m_w_ready),
		.m_b(m_b), .m_b_valid(m_b_valid), .m_b_ready(m_b_ready),
		.m_ar(m_ar), .m_ar_valid(m_ar_valid), .m_ar_ready(m_ar_ready),
		.m_r(m_r), .m_r_valid(m_r_valid), .m_r_ready(m_r_ready),
		.s_aw(arb_aw), .s_aw_valid(arb_aw_valid), .s_aw_ready(arb_aw_ready),
		.s_w(arb_w), .s_w_valid(arb_w_valid), .s_w_ready(arb_w_ready),
		.s_b(arb_b), .s_b_valid(arb_b_valid), .s_b_ready(arb_b_ready),
		.s_ar(arb_ar), .s_ar_valid(arb_ar_valid), .s_ar_ready(arb_ar_ready),
		.s_r(arb_r), .s_r_valid(arb_r_valid), .s_r_ready(arb_r_ready)
	);

	// Request slices run toward the RAM
	axi_skid_buffer #(.payload_t(axi_ram_pkg::axi_aw_t)) aw_slice_i (
		.aclk(aclk), .aresetn(aresetn),
		.in_data(arb_aw), .in_valid(arb_aw_valid), .in_ready(arb_aw_ready),
		.out_data(ram_aw), .out_valid(ram_aw_valid), .out_ready(ram_aw_ready)
	);

	axi_skid_buffer #(.payload_t(axi_ram_pkg::axi_w_t)) w_slice_i (
		.aclk(aclk), .aresetn(aresetn),
		.in_data(arb_w), .in_valid(arb_w_valid), .in_ready(arb_w_ready),
		.out_data(ram_w), .out_valid(ram_w_valid), .out_ready(ram_w_ready)
	);

	axi_skid_buffer #(.payload_t(axi_ram_pkg::axi_ar_t)) ar_slice_i (
		.aclk(aclk), .aresetn(aresetn),
		.in_data(arb_ar), .in_valid(arb_ar_valid), .in_ready(arb_ar_ready),
		.out_data(ram_ar), .out_valid(ram_ar_valid), .out_ready(ram_ar_ready)
	);

	// Response slices run back toward the arbiter
	axi_skid_buffer #(.payload_t(axi_ram_pkg::axi_b_t)) b_slice_i (
		.aclk(aclk), .aresetn(aresetn),
		.in_data(ram_b), .in_valid(ram_b_valid), .in_ready(ram_b_ready),
		.out_data(arb_b), .out_valid(arb_b_valid), .out_ready(arb_b_ready)
	);

	axi_skid_buffer #(.payload_t(axi_ram_pkg::axi_r_t)) r_slice_i (
		.aclk(aclk), .aresetn(aresetn),
		.in_data(ram_r), .in_valid(ram_r_valid), .in_ready(ram_r_ready),
		.out_data(arb_r), .out_valid(arb_r_valid), .out_ready(arb_r_ready)
	);

	axi_ram ram_i (
		.aclk(aclk), .aresetn(aresetn),
		.aw(ram_aw), .aw_valid(ram_aw_valid), .aw_ready(ram_aw_ready),
		.w(ram_w), .w_valid(ram_w_valid), .w_ready(ram_w_ready),
		.b(ram_b), .b_valid(ram_b_valid), .b_ready(ram_b_ready),
		.ar(ram_ar), .ar_valid(ram_ar_valid), .ar_ready(ram_ar_ready),
		.r(ram_r), .r_valid(ram_r_valid), .r_ready(ram_r_ready)
	);

endmodule

/* dv/tb_checker.sv */
// Testbench monitor that watches the master ports and compares responses with the golden file
`timescale 1ns/100ps

module tb_checker (
	input logic aclk,
	input logic aresetn,
	input logic [axi_ram_pkg::NUM_MASTERS-1:0] m_aw_ready,
	input logic [axi_ram_pkg::NUM_MASTERS-1:0] m_w_ready,
	input axi_ram_pkg::axi_b_t [axi_ram_pkg::NUM_MASTERS-1:0] m_b,
	input logic [axi_ram_pkg::NUM_MASTERS-1:0] m_b_valid,
	input logic [axi_ram_pkg::NUM_MASTERS-1:0] m_b_ready,
	input logic [axi_ram_pkg::NUM_MASTERS-1:0] m_ar_ready,
	input axi_ram_pkg::axi_r_t [axi_ram_pkg::NUM_MASTERS-1:0] m_r,
	input logic [axi_ram_pkg::NUM_MASTERS-1:0] m_r_valid,
	input logic [axi_ram_pkg::NUM_MASTERS-1:0] m_r_ready,
	output int value_errors,
	output int other_errors,
	output int pending_ops
);

	localparam GOLDEN_FILE = "dv/golden_ops.txt";
	localparam int OP_COUNT = 20;
	localparam int FIELDS = 17;
	localparam int F_PORT = 0;
	localparam int F_KIND = 1;
	localparam int F_ID = 2;
	localparam int F_LEN = 4;
	localparam int F_EXP = 13;
	localparam int KIND_WRITE = 0;
	localparam int KIND_READ = 1;
	localparam int KIND_SYNC = 2;
	localparam int N = axi_ram_pkg::NUM_MASTERS;

	logic [31:0] golden [OP_COUNT*FIELDS];
	// Per port, the golden line numbers of its bursts in issue order
	int port_ops [N][OP_COUNT];
	int port_op_count [N];
	int next_op [N];
	int beat_index [N];
	logic idle_checked;

	task automatic compare_field(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
			value_errors++;
		end
	endtask

	// Port state right after reset
	task automatic check_idle_ports();
		for (int p = 0; p < N; p++) begin
			compare_field($sformatf("m_aw_ready[%0d]", p), 32'd1, m_aw_ready[p]);
			compare_field($sformatf("m_ar_ready[%0d]", p), 32'd1, m_ar_ready[p]);
			compare_field($sformatf("m_w_ready[%0d]", p), 32'd0, m_w_ready[p]);
			compare_field($sformatf("m_b_valid[%0d]", p), 32'd0, m_b_valid[p]);
			compare_field($sformatf("m_r_valid[%0d]", p), 32'd0, m_r_valid[p]);
		end
	endtask

	task automatic check_write_response(input int p);
		int op;
		if (next_op[p] >= port_op_count[p]) begin
			$display("Write response on port %0d while no burst is outstanding", p);
			other_errors++;
		end else begin
			op = port_ops[p][next_op[p]];
			if (golden[op*FIELDS+F_KIND] != KIND_WRITE) begin
				$display("Write response on port %0d while a read burst is outstanding", p);
				other_errors++;
			end else begin
				compare_field($sformatf("m_b[%0d].id", p), golden[op*FIELDS+F_ID], m_b[p].id);
				compare_field($sformatf("m_b[%0d].resp", p), axi_ram_pkg::RESP_OKAY, m_b[p].resp);
				next_op[p]++;
				pending_ops--;
			end
		end
	endtask

	task automatic check_read_beat(input int p);
		int op;
		int len;
		if (next_op[p] >= port_op_count[p]) begin
			$display("Read data on port %0d while no burst is outstanding", p);
			other_errors++;
		end else begin
			op = port_ops[p][next_op[p]];
			len = golden[op*FIELDS+F_LEN];
			if (golden[op*FIELDS+F_KIND] != KIND_READ) begin
				$display("Read data on port %0d while a write burst is outstanding", p);
				other_errors++;
			end else begin
				compare_field($sformatf("m_r[%0d].id", p), golden[op*FIELDS+F_ID], m_r[p].id);
				compare_field($sformatf("m_r[%0d].data", p),
					golden[op*FIELDS+F_EXP+beat_index[p]], m_r[p].data);
				compare_field($sformatf("m_r[%0d].resp", p), axi_ram_pkg::RESP_OKAY, m_r[p].resp);
				compare_field($sformatf("m_r[%0d].last", p), beat_index[p] == len, m_r[p].last);
				// Close the burst on last or on beat len, whichever shows first
				if (m_r[p].last || beat_index[p] == len) begin
					next_op[p]++;
					beat_index[p] = 0;
					pending_ops--;
				end else begin
					beat_index[p]++;
				end
			end
		end
	endtask

	initial begin
		int port;
		value_errors = 0;
		other_errors = 0;
		pending_ops = 0;
		idle_checked = 1'b0;
		for (int p = 0; p < N; p++) begin
			port_op_count[p] = 0;
			next_op[p] = 0;
			beat_index[p] = 0;
		end
		$readmemh(GOLDEN_FILE, golden);
		for (int op = 0; op < OP_COUNT; op++) begin
			if (golden[op*FIELDS+F_KIND] != KIND_SYNC) begin
				port = golden[op*FIELDS+F_PORT];
				port_ops[port][port_op_count[port]] = op;
				port_op_count[port]++;
				pending_ops++;
			end
		end
	end

	always @(posedge aclk) begin
		if (aresetn) begin
			if (!idle_checked) begin
				check_idle_ports();
				idle_checked = 1'b1;
			end
			for (int p = 0; p < N; p++) begin
				if (m_b_valid[p] && m_b_ready[p]) begin
					check_write_response(p);
				end
				if (m_r_valid[p] && m_r_ready[p]) begin
					check_read_beat(p);
				end
			end
		end
	end

endmodule

/* dv/tb_top.sv */
// Testbench top for the shared AXI4 RAM, drives both master ports from the golden operation file
`timescale 1ns/100ps

module tb_top;

	localparam GOLDEN_FILE = "dv/golden_ops.txt";
	localparam int OP_COUNT = 20;
	localparam int FIELDS = 17;
	localparam int F_PORT = 0;
	localparam int F_KIND = 1;
	localparam int F_ID = 2;
	localparam int F_ADDR = 3;
	localparam int F_LEN = 4;
	localparam int F_DATA = 5;
	localparam int F_STRB = 9;
	localparam int KIND_WRITE = 0;
	localparam int KIND_SYNC = 2;
	localparam int RESET_CYCLES = 8;
	localparam int TIMEOUT_CYCLES = OP_COUNT * 64;
	localparam int N = axi_ram_pkg::NUM_MASTERS;

	logic aclk = 1'b0;
	logic aresetn;
	axi_ram_pkg::axi_aw_t [N-1:0] m_aw;
	logic [N-1:0] m_aw_valid;
	logic [N-1:0] m_aw_ready;
	axi_ram_pkg::axi_w_t [N-1:0] m_w;
	logic [N-1:0] m_w_valid;
	logic [N-1:0] m_w_ready;
	axi_ram_pkg::axi_b_t [N-1:0] m_b;
	logic [N-1:0] m_b_valid;
	logic [N-1:0] m_b_ready;
	axi_ram_pkg::axi_ar_t [N-1:0] m_ar;
	logic [N-1:0] m_ar_valid;
	logic [N-1:0] m_ar_ready;
	axi_ram_pkg::axi_r_t [N-1:0] m_r;
	logic [N-1:0] m_r_valid;
	logic [N-1:0] m_r_ready;

	logic [31:0] golden [OP_COUNT*FIELDS];
	int sync_level [N];
	int cycle_count = 0;
	int missing_ops = 0;
	int value_errors;
	int other_errors;
	int pending_ops;

	axi_ram_subsystem dut_i (
		.aclk(aclk), .aresetn(aresetn),
		.m_aw(m_aw), .m_aw_valid(m_aw_valid), .m_aw_ready(m_aw_ready),
		.m_w(m_w), .m_w_valid(m_w_valid), .m_w_ready(m_w_ready),
		.m_b(m_b), .m_b_valid(m_b_valid), .m_b_ready(m_b_ready),
		.m_ar(m_ar), .m_ar_valid(m_ar_valid), .m_ar_ready(m_ar_ready),
		.m_r(m_r), .m_r_valid(m_r_valid), .m_r_ready(m_r_ready)
	);

	tb_checker checker_i (
		.aclk(aclk), .aresetn(aresetn),
		.m_aw_ready(m_aw_ready), .m_w_ready(m_w_ready), .m_ar_ready(m_ar_ready),
		.m_b(m_b), .m_b_valid(m_b_valid), .m_b_ready(m_b_ready),
		.m_r(m_r), .m_r_valid(m_r_valid), .m_r_ready(m_r_ready),
		.value_errors(value_errors), .other_errors(other_errors), .pending_ops(pending_ops)
	);

	always #5 aclk = ~aclk;

	function automatic logic all_synced(input int level);
		logic reached;
		reached = 1'b1;
		for (int p = 0; p < N; p++) begin
			if (sync_level[p] < level) begin
				reached = 1'b0;
			end
		end
		return reached;
	endfunction

	////////////////////
	// Burst drivers
	task automatic write_burst(input int p, input int op);
		int base;
		int len;
		axi_ram_pkg::axi_aw_t aw_beat;
		axi_ram_pkg::axi_w_t w_beat;
		base = op * FIELDS;
		len = golden[base+F_LEN];
		aw_beat.id = golden[base+F_ID][axi_ram_pkg::ID_WIDTH-1:0];
		aw_beat.addr = golden[base+F_ADDR][axi_ram_pkg::ADDR_WIDTH-1:0];
		aw_beat.len = golden[base+F_LEN][7:0];
		m_aw[p] <= aw_beat;
		m_aw_valid[p] <= 1'b1;
		do @(posedge aclk); while (!m_aw_ready[p]);
		m_aw_valid[p] <= 1'b0;
		for (int i = 0; i <= len; i++) begin
			w_beat.data = golden[base+F_DATA+i];
			w_beat.strb = golden[base+F_STRB+i][axi_ram_pkg::STRB_WIDTH-1:0];
			w_beat.last = (i == len);
			m_w[p] <= w_beat;
			m_w_valid[p] <= 1'b1;
			do @(posedge aclk); while (!m_w_ready[p]);
		end
		m_w_valid[p] <= 1'b0;
		do @(posedge aclk); while (!(m_b_valid[p] && m_b_ready[p]));
	endtask

	task automatic read_burst(input int p, input int op);
		int base;
		axi_ram_pkg::axi_ar_t ar_beat;
		base = op * FIELDS;
		ar_beat.id = golden[base+F_ID][axi_ram_pkg::ID_WIDTH-1:0];
		ar_beat.addr = golden[base+F_ADDR][axi_ram_pkg::ADDR_WIDTH-1:0];
		ar_beat.len = golden[base+F_LEN][7:0];
		m_ar[p] <= ar_beat;
		m_ar_valid[p] <= 1'b1;
		do @(posedge aclk); while (!m_ar_ready[p]);
		m_ar_valid[p] <= 1'b0;
		do @(posedge aclk); while (!(m_r_valid[p] && m_r_ready[p] && m_r[p].last));
	endtask

	// Walk the golden list, taking this port's lines and every sync point
	task automatic run_port(input int p);
		int level;
		level = 0;
		for (int op = 0; op < OP_COUNT; op++) begin
			if (golden[op*FIELDS+F_KIND] == KIND_SYNC) begin
				level++;
				sync_level[p] = level;
				while (!all_synced(level)) begin
					@(posedge aclk);
				end
			end else if (golden[op*FIELDS+F_PORT] == p) begin
				if (golden[op*FIELDS+F_KIND] == KIND_WRITE) begin
					write_burst(p, op);
				end else begin
					read_burst(p, op);
				end
			end
		end
	endtask

	task automatic end_run(input logic timed_out);
		$display("Errors: %0d value mismatches, %0d other failures, %0d missing bursts, %0d timeouts",
			value_errors, other_errors, missing_ops, timed_out);
		if (timed_out || (value_errors + other_errors + missing_ops) != 0) begin
			$display("Simulation FAILED");
		end else begin
			$display("Simulation PASSED");
		end
		$finish;
	endtask

	////////////////////
	// Sequence
	initial begin
		aresetn = 1'b0;
		m_aw = '0;
		m_aw_valid = '0;
		m_w = '0;
		m_w_valid = '0;
		m_ar = '0;
		m_ar_valid = '0;
		for (int p = 0; p < N; p++) begin
			sync_level[p] = 0;
		end
		$readmemh(GOLDEN_FILE, golden);
		repeat (RESET_CYCLES) @(posedge aclk);
		aresetn <= 1'b1;
		repeat (2) @(posedge aclk);
		fork
			run_port(0);
			run_port(1);
		join
		// Let the checker take the final beats
		repeat (4) @(posedge aclk);
		if (pending_ops != 0) begin
			$display("%0d bursts from the golden file never completed", pending_ops);
			missing_ops = pending_ops;
		end
		end_run(1'b0);
	end

	// Response back-pressure, ready high three cycles in four
	initial begin
		int seed_value;
		logic [31:0] rnd;
		m_b_ready = '0;
		m_r_ready = '0;
		seed_value = 32'h1139;
		rnd = $urandom(seed_value);
		forever begin
			@(posedge aclk);
			rnd = $urandom;
			for (int p = 0; p < N; p++) begin
				m_b_ready[p] <= (rnd[2*p +: 2] != 2'b00);
				m_r_ready[p] <= (rnd[8+2*p +: 2] != 2'b00);
			end
		end
	end

	always @(posedge aclk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles with bursts still in flight", TIMEOUT_CYCLES);
			end_run(1'b1);
		end
	end

endmodule

/* dv/golden_ops.txt */
// Golden operations for both master ports, one burst per line, all values hex
// Columns: port kind id addr len, then data0 to data3, strb0 to strb3, expected read words 0 to 3
// Kind 0 is a write burst, 1 a read burst, 2 a sync point where both ports wait for each other
// Write lines keep the expected words zero and read lines keep data and strobes zero
// Words past beat len are unused and kept zero

0 0 1 000 03 11111111 22222222 33333333 44444444 F F F F 00000000 00000000 00000000 00000000
1 0 2 100 03 A0A0A0A0 A1A1A1A1 A2A2A2A2 A3A3A3A3 F F F F 00000000 00000000 00000000 00000000
0 2 0 000 00 00000000 00000000 00000000 00000000 0 0 0 0 00000000 00000000 00000000 00000000
0 1 3 100 03 00000000 00000000 00000000 00000000 0 0 0 0 A0A0A0A0 A1A1A1A1 A2A2A2A2 A3A3A3A3
1 1 4 000 03 00000000 00000000 00000000 00000000 0 0 0 0 11111111 22222222 33333333 44444444
0 2 0 000 00 00000000 00000000 00000000 00000000 0 0 0 0 00000000 00000000 00000000 00000000
0 0 5 004 01 DEADBEEF CAFEF00D 00000000 00000000 3 C 0 0 00000000 00000000 00000000 00000000
1 0 6 200 00 5A5A5A5A 00000000 00000000 00000000 F 0 0 0 00000000 00000000 00000000 00000000
0 1 7 000 03 00000000 00000000 00000000 00000000 0 0 0 0 11111111 2222BEEF CAFE3333 44444444
1 0 8 200 00 12345678 00000000 00000000 00000000 5 0 0 0 00000000 00000000 00000000 00000000
0 2 0 000 00 00000000 00000000 00000000 00000000 0 0 0 0 00000000 00000000 00000000 00000000
1 1 9 200 00 00000000 00000000 00000000 00000000 0 0 0 0 5A345A78 00000000 00000000 00000000
0 0 A 300 02 01020304 05060708 090A0B0C 00000000 F F F 0 00000000 00000000 00000000 00000000
0 1 B 300 02 00000000 00000000 00000000 00000000 0 0 0 0 01020304 05060708 090A0B0C 00000000
1 0 C 104 01 FFFFFFFF 00000000 00000000 00000000 8 1 0 0 00000000 00000000 00000000 00000000
1 1 D 104 01 00000000 00000000 00000000 00000000 0 0 0 0 FFA1A1A1 A2A2A200 00000000 00000000
0 2 0 000 00 00000000 00000000 00000000 00000000 0 0 0 0 00000000 00000000 00000000 00000000
0 1 E 100 03 00000000 00000000 00000000 00000000 0 0 0 0 A0A0A0A0 FFA1A1A1 A2A2A200 A3A3A3A3
1 1 F 300 02 00000000 00000000 00000000 00000000 0 0 0 0 01020304 05060708 090A0B0C 00000000
0 1 0 200 00 00000000 00000000 00000000 00000000 0 0 0 0 5A345A78 00000000 00000000 00000000

/* files.f */
source/axi_ram_pkg.sv
source/axi_skid_buffer.sv
source/axi_ram.sv
source/axi_burst_arbiter.sv
source/axi_ram_subsystem.sv
dv/tb_checker.sv
dv/tb_top.sv
